// ==== opc5ls_defines.svh ====
`ifndef OPC5LS_DEFINES_SVH
`define OPC5LS_DEFINES_SVH

// Machine word and bus width
`define OPC5LS_DATA_W 16

// Register file geometry, r15 is the program counter
`define OPC5LS_NUM_REGS 16
`define OPC5LS_REG_AW 4
`define OPC5LS_PC_REG 4'hf

// Processor status register width
`define OPC5LS_PSR_W 8

`define OPC5LS_INT_VECTOR 16'h0002  // Entry on hardware or software interrupt
`define OPC5LS_RESET_PC 16'h0000    // First fetch after reset

`endif

// ==== opc5ls_isa_pkg.sv ====
`include "opc5ls_defines.svh"

package opc5ls_isa_pkg;

   typedef enum logic [3:0] {
      op_mov  = 4'h0,
      op_and  = 4'h1,
      op_or   = 4'h2,
      op_xor  = 4'h3,
      op_add  = 4'h4,
      op_adc  = 4'h5,
      op_sto  = 4'h6,
      op_ld   = 4'h7,
      op_ror  = 4'h8,
      op_not  = 4'h9,
      op_sub  = 4'ha,
      op_sbc  = 4'hb,
      op_cmp  = 4'hc,
      op_cmpc = 4'hd,
      op_bswp = 4'he,
      op_psr  = 4'hf
   } opcode_e;

   // Top bit inverts the selected condition
   typedef enum logic [2:0] {
      pred_always = 3'b000,
      pred_c      = 3'b001,
      pred_z      = 3'b010,
      pred_s      = 3'b011,
      pred_never  = 3'b100,
      pred_nc     = 3'b101,
      pred_nz     = 3'b110,
      pred_ns     = 3'b111
   } pred_e;

   typedef struct packed {
      pred_e                     pred;
      logic                      len;     // Second word follows
      opcode_e                   opcode;
      logic [`OPC5LS_REG_AW-1:0] src;
      logic [`OPC5LS_REG_AW-1:0] dst;
   } instr_t;

   typedef struct packed {
      logic   is_cmp;
      logic   is_rti;
      logic   put_psr;
      logic   get_psr;
      logic   is_sto;
      logic   is_ld;
      instr_t instr;
   } ir_t;

   typedef struct packed {
      logic [3:0] swi_id;
      logic       enable_int;
      logic       sign;
      logic       carry;
      logic       zero;
   } psr_t;

endpackage

// ==== opc5ls_ctrl_pkg.sv ====
`include "opc5ls_defines.svh"

package opc5ls_ctrl_pkg;

   import opc5ls_isa_pkg::*;

   typedef enum logic [2:0] {
      s_fetch0 = 3'h0,
      s_fetch1 = 3'h1,
      s_ea_ed  = 3'h2,
      s_rdmem  = 3'h3,
      s_exec   = 3'h4,
      s_wrmem  = 3'h5,
      s_int    = 3'h6
   } fsm_e;

   // Decode to execute and result
   typedef struct packed {
      fsm_e                      state;
      ir_t                       ir;
      logic [`OPC5LS_REG_AW-1:0] rf_radr;
      logic                      take_int;  // Only meaningful in exec and wrmem
   } dec_ctrl_t;

   // Execute to decode and result
   typedef struct packed {
      logic [`OPC5LS_DATA_W-1:0] result;
      psr_t                      psr_next;
      logic [`OPC5LS_DATA_W-1:0] opr;     // Immediate, then address, then load data
   } exe_out_t;

endpackage

// ==== opc5ls_decode.sv ====
`timescale 1ns/100ps
`include "opc5ls_defines.svh"

module opc5ls_decode
   import opc5ls_isa_pkg::*, opc5ls_ctrl_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset_b,
   input  logic                      int_b,
   input  logic [`OPC5LS_DATA_W-1:0] din,
   input  psr_t                      psr,
   input  exe_out_t                  exe,
   output dec_ctrl_t                 ctrl
);

   fsm_e                      state_q;
   ir_t                       ir_q;
   logic [`OPC5LS_REG_AW-1:0] rf_radr_q;
   instr_t                    din_instr;
   logic                      pred_ir;
   logic                      pred_din;
   logic                      skip_eaed;
   logic                      take_int;

   function automatic logic pred_true(pred_e p, psr_t f);
      logic r;
      case (p)
         pred_always: r = 1'b1;
         pred_never:  r = 1'b0;
         pred_c:      r = f.carry;
         pred_nc:     r = !f.carry;
         pred_z:      r = f.zero;
         pred_nz:     r = !f.zero;
         pred_s:      r = f.sign;
         pred_ns:     r = !f.sign;
      endcase
      return r;
   endfunction

   // Flags worked out once as the word is latched
   function automatic ir_t predecode(instr_t i);
      ir_t r;
      r.instr   = i;
      r.is_ld   = (i.opcode == op_ld);
      r.is_sto  = (i.opcode == op_sto);
      r.is_cmp  = (i.opcode == op_cmp) || (i.opcode == op_cmpc);
      r.get_psr = (i.opcode == op_psr) && (i.src == '0);
      r.put_psr = (i.opcode == op_psr) && (i.dst == '0);
      r.is_rti  = (i.opcode == op_psr) && (i.dst == `OPC5LS_PC_REG);
      return r;
   endfunction

   assign din_instr = instr_t'(din);
   assign pred_din  = pred_true(din_instr.pred, psr);
   assign pred_ir   = pred_true(ir_q.instr.pred, psr);
   assign skip_eaed = !((rf_radr_q != '0) || ir_q.is_ld || ir_q.is_sto);  // r0 source, no memory

   assign take_int = ((state_q == s_exec) || (state_q == s_wrmem))
                     && ((!int_b && psr.enable_int) || (ir_q.put_psr && (|exe.psr_next.swi_id)));

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         state_q <= s_fetch0;
      else
         case (state_q)
            s_fetch0: state_q <= din_instr.len ? s_fetch1 : (!pred_din ? s_fetch0 : s_ea_ed);
            s_fetch1: state_q <= !pred_ir ? s_fetch0 : (skip_eaed ? s_exec : s_ea_ed);
            s_ea_ed:  state_q <= !pred_ir ? s_fetch0 :
                                 ir_q.is_ld ? s_rdmem : (ir_q.is_sto ? s_wrmem : s_exec);
            s_rdmem:  state_q <= s_exec;
            s_exec:   state_q <= take_int ? s_int :
                                 (ir_q.instr.dst == `OPC5LS_PC_REG) ? s_fetch0 :
                                 (din_instr.len ? s_fetch1 : s_ea_ed);  // Overlapped fetch
            s_wrmem:  state_q <= take_int ? s_int : s_fetch0;
            default:  state_q <= s_fetch0;
         endcase
   end

   always_ff @(posedge clk)
   begin
      case (state_q)
         s_fetch0, s_exec: rf_radr_q <= din_instr.src;
         s_fetch1:         rf_radr_q <= skip_eaed ? ir_q.instr.dst : ir_q.instr.src;
         default:          rf_radr_q <= ir_q.instr.dst;
      endcase
      if ((state_q == s_fetch0) || (state_q == s_exec))
         ir_q <= predecode(din_instr);
   end

   assign ctrl.state    = state_q;
   assign ctrl.ir       = ir_q;
   assign ctrl.rf_radr  = rf_radr_q;
   assign ctrl.take_int = take_int;

   a_state_legal : assert property (@(posedge clk) disable iff (!reset_b)
      state_q inside {s_fetch0, s_fetch1, s_ea_ed, s_rdmem, s_exec, s_wrmem, s_int})
      else $error("decode state left the legal set: %0h", state_q);

endmodule

// ==== opc5ls_execute.sv ====
`timescale 1ns/100ps
`include "opc5ls_defines.svh"

module opc5ls_execute
   import opc5ls_isa_pkg::*, opc5ls_ctrl_pkg::*;
(
   input  logic                      clk,
   input  logic [`OPC5LS_DATA_W-1:0] din,
   input  dec_ctrl_t                 ctrl,
   input  logic [`OPC5LS_DATA_W-1:0] reg_rdata,
   input  psr_t                      psr,
   output exe_out_t                  exe
);

   logic [`OPC5LS_DATA_W-1:0] opr_q;
   logic [`OPC5LS_DATA_W-1:0] result;
   logic [`OPC5LS_DATA_W:0]   sum;
   logic                      carry;
   opcode_e                   op;
   psr_t                      psr_next;

   assign op = ctrl.ir.instr.opcode;

   always_ff @(posedge clk)
   begin
      case (ctrl.state)
         s_fetch0, s_exec: opr_q <= '0;
         s_fetch1:         opr_q <= din;               // Immediate or displacement
         s_ea_ed:          opr_q <= reg_rdata + opr_q;  // Register plus displacement
         default:          opr_q <= din;               // Load data
      endcase
   end

   always_comb
   begin
      result = opr_q;
      carry  = psr.carry;
      sum    = '0;
      case (op)
         op_ld, op_mov, op_psr, op_sto:
            result = ctrl.ir.get_psr ? {{(`OPC5LS_DATA_W-`OPC5LS_PSR_W){1'b0}}, psr} : opr_q;
         op_and, op_or:
            result = op[0] ? (reg_rdata & opr_q) : (reg_rdata | opr_q);
         op_add, op_adc:
         begin
            sum    = {1'b0, reg_rdata} + {1'b0, opr_q} + (op[0] & psr.carry);
            result = sum[`OPC5LS_DATA_W-1:0];
            carry  = sum[`OPC5LS_DATA_W];
         end
         op_sub, op_sbc, op_cmp, op_cmpc:
         begin
            sum    = {1'b0, reg_rdata} + {1'b0, ~opr_q} + (op[0] ? psr.carry : 1'b1);  // Borrow as inverted carry
            result = sum[`OPC5LS_DATA_W-1:0];
            carry  = sum[`OPC5LS_DATA_W];
         end
         op_xor, op_bswp:
            result = op[3] ? {opr_q[7:0], opr_q[15:8]} : (reg_rdata ^ opr_q);
         op_not:
            result = ~opr_q;
         op_ror:
         begin
            result = {psr.carry, opr_q[`OPC5LS_DATA_W-1:1]};  // Rotate through carry
            carry  = opr_q[0];
         end
      endcase
   end

   always_comb
   begin
      psr_next = psr;
      if (ctrl.ir.put_psr)
         psr_next = psr_t'(opr_q[`OPC5LS_PSR_W-1:0]);
      else if (ctrl.ir.instr.dst != `OPC5LS_PC_REG)  // Jumps keep the flags
      begin
         psr_next.sign  = result[`OPC5LS_DATA_W-1];
         psr_next.carry = carry;
         psr_next.zero  = ~|result;
      end
   end

   assign exe.result   = result;
   assign exe.psr_next = psr_next;
   assign exe.opr      = opr_q;

endmodule

// ==== opc5ls_result.sv ====
`timescale 1ns/100ps
`include "opc5ls_defines.svh"

module opc5ls_result
   import opc5ls_isa_pkg::*, opc5ls_ctrl_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset_b,
   input  dec_ctrl_t                 ctrl,
   input  exe_out_t                  exe,
   output logic [`OPC5LS_DATA_W-1:0] reg_rdata,
   output psr_t                      psr,
   output logic [`OPC5LS_DATA_W-1:0] address,
   output logic [`OPC5LS_DATA_W-1:0] dout,
   output logic                      rnw
);

   logic [`OPC5LS_DATA_W-1:0] rf_q [0:`OPC5LS_NUM_REGS-2];  // r0 to r14
   logic [`OPC5LS_DATA_W-1:0] pc_q;
   logic [`OPC5LS_DATA_W-1:0] pci_q;
   psr_t                      psr_q;
   psr_t                      psri_q;
   psr_t                      psr_rti;
   logic [`OPC5LS_REG_AW-1:0] rf_wadr;
   logic                      pc_dst;

   assign pc_dst = (ctrl.ir.instr.dst == `OPC5LS_PC_REG);

   // r0 soaks up compare and jump results
   assign rf_wadr = (ctrl.ir.is_cmp || pc_dst) ? '0 : ctrl.ir.instr.dst;

   always_ff @(posedge clk)
   begin
      if (ctrl.state == s_exec)
         rf_q[rf_wadr] <= exe.result;
   end

   always_comb
   begin
      if (ctrl.rf_radr == `OPC5LS_PC_REG)
         reg_rdata = pc_q;
      else if (ctrl.rf_radr == '0)
         reg_rdata = '0;
      else
         reg_rdata = rf_q[ctrl.rf_radr];
   end

   always_comb
   begin
      psr_rti        = psri_q;
      psr_rti.swi_id = '0;  // Software interrupt is done on return
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         pc_q   <= `OPC5LS_RESET_PC;
         pci_q  <= '0;
         psr_q  <= '0;
         psri_q <= '0;
      end
      else
         case (ctrl.state)
            s_int:
            begin
               pc_q             <= `OPC5LS_INT_VECTOR;
               pci_q            <= pc_q;
               psri_q           <= psr_q;
               psr_q.enable_int <= 1'b0;
            end
            s_fetch0, s_fetch1:
               pc_q <= pc_q + 1'b1;
            s_exec:
            begin
               if (ctrl.ir.is_rti)
                  pc_q <= pci_q;
               else if (pc_dst)
                  pc_q <= exe.result;
               else if (!ctrl.take_int)
                  pc_q <= pc_q + 1'b1;  // Overlapped fetch of the next word
               psr_q <= ctrl.ir.is_rti ? psr_rti : exe.psr_next;
            end
            default: ;
         endcase
   end

   assign psr     = psr_q;
   assign dout    = reg_rdata;
   assign rnw     = (ctrl.state != s_wrmem);
   assign address = ((ctrl.state == s_wrmem) || (ctrl.state == s_rdmem)) ? exe.opr : pc_q;

   // A store comes straight after its address phase and lasts one cycle
   a_store_one_cycle : assert property (@(posedge clk) disable iff (!reset_b)
      !rnw |-> ($past(ctrl.state) == s_ea_ed) ##1 rnw)
      else $error("write strobe outside a single wrmem cycle");

   // A jump drops the overlapped word and fetches from its target next
   a_pc_dest : assert property (@(posedge clk) disable iff (!reset_b)
      (ctrl.state == s_exec && pc_dst && !ctrl.ir.is_rti && !ctrl.take_int)
      |=> ((ctrl.state == s_fetch0) && (address == $past(exe.result))))
      else $error("jump target not fetched in the next cycle");

endmodule

// ==== opc5ls_core.sv ====
`timescale 1ns/100ps
`include "opc5ls_defines.svh"

module opc5ls_core
   import opc5ls_isa_pkg::*, opc5ls_ctrl_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset_b,
   input  logic                      int_b,
   input  logic [`OPC5LS_DATA_W-1:0] din,
   output logic [`OPC5LS_DATA_W-1:0] dout,
   output logic [`OPC5LS_DATA_W-1:0] address,
   output logic                      rnw
);

   dec_ctrl_t                 ctrl;
   exe_out_t                  exe;
   psr_t                      psr;
   logic [`OPC5LS_DATA_W-1:0] reg_rdata;

   opc5ls_decode i_opc5ls_decode (
      .clk     (clk),
      .reset_b (reset_b),
      .int_b   (int_b),
      .din     (din),
      .psr     (psr),
      .exe     (exe),
      .ctrl    (ctrl)
   );

   opc5ls_execute i_opc5ls_execute (
      .clk       (clk),
      .din       (din),
      .ctrl      (ctrl),
      .reg_rdata (reg_rdata),
      .psr       (psr),
      .exe       (exe)
   );

   opc5ls_result i_opc5ls_result (
      .clk       (clk),
      .reset_b   (reset_b),
      .ctrl      (ctrl),
      .exe       (exe),
      .reg_rdata (reg_rdata),
      .psr       (psr),
      .address   (address),
      .dout      (dout),
      .rnw       (rnw)
   );

endmodule

// ==== tb_opc5ls_memory.sv ====
`timescale 1ns/100ps
`include "opc5ls_defines.svh"

module tb_opc5ls_memory (
   input  logic                      clk,
   input  logic [`OPC5LS_DATA_W-1:0] address,
   input  logic [`OPC5LS_DATA_W-1:0] wdata,
   input  logic                      rnw,
   output logic [`OPC5LS_DATA_W-1:0] rdata
);

   logic [`OPC5LS_DATA_W-1:0] mem [0:65535];

   initial
   begin
      for (int a = 0; a < 65536; a++)
         mem[a] = {a[7:0], a[15:8]} ^ 16'h5aa5;  // Filler depends on the full address
   end

   assign rdata = mem[address];  // Same-cycle read

   always @(posedge clk)
   begin
      if (!rnw)
         mem[address] <= wdata;
   end

endmodule

// ==== tb_opc5ls_core.sv ====
`timescale 1ns/100ps
`include "opc5ls_defines.svh"

module tb_opc5ls_core
   import opc5ls_isa_pkg::*;
();

   localparam int PROG_CYCLES = 500;  // Rough length of the test program
   localparam int WATCHDOG_NS = PROG_CYCLES * 4 * 10;
   localparam logic [15:0] MARK_ADDR   = 16'h01e0;
   localparam logic [15:0] SYNC_ON     = 16'h01f0;
   localparam logic [15:0] SYNC_OFF    = 16'h01f1;
   localparam logic [15:0] DONE_ADDR   = 16'h01ff;
   localparam logic [15:0] HANDLER_END = 16'h0008;
   localparam logic [15:0] LD_A        = 16'h5a3c;
   localparam logic [15:0] LD_B        = 16'h1357;

   logic        clk;
   logic        reset_b;
   logic        int_b;
   logic [15:0] din;
   logic [15:0] dout;
   logic [15:0] address;
   logic        rnw;

   logic [15:0] loc;
   logic [15:0] exp_val [0:255];
   bit          exp_valid [0:255];
   int          write_cnt [0:255];
   int          value_errors = 0;
   int          other_errors = 0;
   int          int_entries = 0;
   int          returns_checked = 0;
   logic [15:0] ret_addr = '0;
   logic [15:0] prev_addr = '0;
   logic        marker_seen = 1'b0;
   logic        ret_pending = 1'b0;
   logic        first_cycle = 1'b1;
   logic        reset_seen = 1'b0;
   logic        done_seen = 1'b0;
   logic [31:0] rng = 32'h33ba;

   opc5ls_core i_opc5ls_core (
      .clk     (clk),
      .reset_b (reset_b),
      .int_b   (int_b),
      .din     (din),
      .dout    (dout),
      .address (address),
      .rnw     (rnw)
   );

   tb_opc5ls_memory i_memory (
      .clk     (clk),
      .address (address),
      .wdata   (dout),
      .rnw     (rnw),
      .rdata   (din)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [15:0] encode(input logic [2:0] p, input logic len,
                                          input logic [3:0] op, input logic [3:0] src,
                                          input logic [3:0] dst);
      return {p, len, op, src, dst};
   endfunction

   task automatic short_op(input logic [2:0] p, input logic [3:0] op,
                           input logic [3:0] src, input logic [3:0] dst);
      i_memory.mem[loc] = encode(p, 1'b0, op, src, dst);
      loc = loc + 1'b1;
   endtask

   task automatic long_op(input logic [2:0] p, input logic [3:0] op, input logic [3:0] src,
                          input logic [3:0] dst, input logic [15:0] imm);
      i_memory.mem[loc] = encode(p, 1'b1, op, src, dst);
      i_memory.mem[loc + 1'b1] = imm;
      loc = loc + 2'd2;
   endtask

   task automatic expect_store(input logic [15:0] a, input logic [15:0] v);
      exp_valid[a[7:0]] = 1'b1;
      exp_val[a[7:0]]   = v;
   endtask

   task automatic load_program();
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] r;
      logic [15:0] loop_on;
      logic [15:0] loop_off;
      logic [15:0] halt;
      logic        c;
      a = 16'h1234;
      b = 16'h0ff0;
      for (int i = 0; i < 256; i++)
      begin
         exp_valid[i] = 1'b0;
         write_cnt[i] = 0;
      end
      loc = `OPC5LS_RESET_PC;
      long_op(pred_always, op_mov, 4'd0, 4'd15, 16'h0010);
      // Interrupt handler at the vector
      long_op(pred_always, op_mov, 4'd0, 4'd13, 16'hbeef);
      long_op(pred_always, op_sto, 4'd0, 4'd13, MARK_ADDR);
      short_op(pred_always, op_psr, 4'd0, 4'd15);  // rti
      loc = 16'h0010;
      long_op(pred_always, op_mov, 4'd0, 4'd1, a);
      long_op(pred_always, op_mov, 4'd0, 4'd2, b);
      long_op(pred_always, op_mov, 4'd0, 4'd3, 16'hf00f);
      short_op(pred_always, op_add, 4'd1, 4'd3);
      long_op(pred_always, op_sto, 4'd0, 4'd3, 16'h0100);
      long_op(pred_always, op_mov, 4'd0, 4'd4, 16'h0001);
      short_op(pred_always, op_adc, 4'd1, 4'd4);
      long_op(pred_always, op_sto, 4'd0, 4'd4, 16'h0101);
      long_op(pred_always, op_mov, 4'd0, 4'd5, 16'h5000);
      short_op(pred_always, op_sub, 4'd2, 4'd5);
      long_op(pred_always, op_sto, 4'd0, 4'd5, 16'h0102);
      long_op(pred_always, op_mov, 4'd0, 4'd6, 16'h0100);
      short_op(pred_always, op_sbc, 4'd1, 4'd6);
      long_op(pred_always, op_sto, 4'd0, 4'd6, 16'h0103);
      long_op(pred_always, op_mov, 4'd0, 4'd7, 16'hff00);
      short_op(pred_always, op_and, 4'd1, 4'd7);
      long_op(pred_always, op_sto, 4'd0, 4'd7, 16'h0104);
      long_op(pred_always, op_mov, 4'd0, 4'd8, 16'h000f);
      short_op(pred_always, op_or, 4'd2, 4'd8);
      long_op(pred_always, op_sto, 4'd0, 4'd8, 16'h0105);
      long_op(pred_always, op_mov, 4'd0, 4'd9, 16'hffff);
      short_op(pred_always, op_xor, 4'd1, 4'd9);
      long_op(pred_always, op_sto, 4'd0, 4'd9, 16'h0106);
      short_op(pred_always, op_not, 4'd2, 4'd10);
      long_op(pred_always, op_sto, 4'd0, 4'd10, 16'h0107);
      long_op(pred_always, op_psr, 4'd0, 4'd0, 16'h0002);  // Carry set
      short_op(pred_always, op_ror, 4'd1, 4'd11);
      long_op(pred_always, op_sto, 4'd0, 4'd11, 16'h0108);
      short_op(pred_always, op_bswp, 4'd1, 4'd12);
      long_op(pred_always, op_sto, 4'd0, 4'd12, 16'h0109);
      // Compare and predicated stores
      long_op(pred_always, op_mov, 4'd0, 4'd3, a);
      short_op(pred_always, op_cmp, 4'd1, 4'd3);
      long_op(pred_z, op_sto, 4'd0, 4'd1, 16'h0110);
      long_op(pred_nz, op_sto, 4'd0, 4'd1, 16'h0111);
      long_op(pred_c, op_sto, 4'd0, 4'd1, 16'h0112);
      long_op(pred_nc, op_sto, 4'd0, 4'd1, 16'h0113);
      long_op(pred_always, op_sto, 4'd0, 4'd3, 16'h0116);
      long_op(pred_always, op_mov, 4'd0, 4'd4, 16'h0001);
      short_op(pred_always, op_cmp, 4'd1, 4'd4);
      long_op(pred_z, op_sto, 4'd0, 4'd4, 16'h0114);
      long_op(pred_nc, op_sto, 4'd0, 4'd4, 16'h0115);
      // Register plus displacement
      long_op(pred_always, op_mov, 4'd0, 4'd5, 16'h0140);
      long_op(pred_always, op_ld, 4'd5, 4'd6, 16'h0005);
      long_op(pred_always, op_sto, 4'd5, 4'd6, 16'h0030);
      short_op(pred_always, op_ld, 4'd5, 4'd7);
      long_op(pred_always, op_sto, 4'd0, 4'd7, 16'h0171);
      // False predicates
      long_op(pred_always, op_mov, 4'd0, 4'd8, 16'h0000);
      short_op(pred_nz, op_add, 4'd1, 4'd8);
      long_op(pred_nz, op_mov, 4'd0, 4'd8, 16'h7777);
      long_op(pred_never, op_sto, 4'd0, 4'd1, 16'h0131);
      long_op(pred_always, op_sto, 4'd0, 4'd8, 16'h0130);
      long_op(pred_always, op_mov, 4'd0, 4'd9, 16'h4242);
      long_op(pred_always, op_sto, 4'd0, 4'd9, 16'h0132);
      // Interrupts enabled, then disabled
      long_op(pred_always, op_psr, 4'd0, 4'd0, 16'h0008);
      long_op(pred_always, op_sto, 4'd0, 4'd0, SYNC_ON);
      long_op(pred_always, op_mov, 4'd0, 4'd1, 16'd20);
      loop_on = loc;
      long_op(pred_always, op_sub, 4'd0, 4'd1, 16'h0001);
      long_op(pred_nz, op_mov, 4'd0, 4'd15, loop_on);
      long_op(pred_always, op_psr, 4'd0, 4'd0, 16'h0000);
      long_op(pred_always, op_sto, 4'd0, 4'd0, SYNC_OFF);
      long_op(pred_always, op_mov, 4'd0, 4'd1, 16'd10);
      loop_off = loc;
      long_op(pred_always, op_sub, 4'd0, 4'd1, 16'h0001);
      long_op(pred_nz, op_mov, 4'd0, 4'd15, loop_off);
      long_op(pred_always, op_sto, 4'd0, 4'd1, 16'h01f2);
      long_op(pred_always, op_mov, 4'd0, 4'd12, 16'h600d);
      long_op(pred_always, op_sto, 4'd0, 4'd12, DONE_ADDR);
      halt = loc;
      long_op(pred_always, op_mov, 4'd0, 4'd15, halt);
      i_memory.mem[16'h0145] = LD_A;
      i_memory.mem[16'h0140] = LD_B;

      // Expected results from the ISA rules, carry tracked by hand
      {c, r} = {1'b0, 16'hf00f} + {1'b0, a};
      expect_store(16'h0100, r);
      {c, r} = {1'b0, 16'h0001} + {1'b0, a} + c;
      expect_store(16'h0101, r);
      {c, r} = {1'b0, 16'h5000} + {1'b0, ~b} + 1'b1;
      expect_store(16'h0102, r);
      {c, r} = {1'b0, 16'h0100} + {1'b0, ~a} + c;
      expect_store(16'h0103, r);
      expect_store(16'h0104, 16'hff00 & a);
      expect_store(16'h0105, 16'h000f | b);
      expect_store(16'h0106, 16'hffff ^ a);
      expect_store(16'h0107, ~b);
      expect_store(16'h0108, {1'b1, a[15:1]});
      expect_store(16'h0109, {a[7:0], a[15:8]});
      {c, r} = {1'b0, a} + {1'b0, ~a} + 1'b1;
      if (r == '0)
         expect_store(16'h0110, a);
      else
         expect_store(16'h0111, a);
      if (c)
         expect_store(16'h0112, a);
      else
         expect_store(16'h0113, a);
      expect_store(16'h0116, a);  // Compare keeps its destination
      {c, r} = {1'b0, 16'h0001} + {1'b0, ~a} + 1'b1;
      if (r == '0)
         expect_store(16'h0114, 16'h0001);
      if (!c)
         expect_store(16'h0115, 16'h0001);
      expect_store(16'h0170, LD_A);
      expect_store(16'h0171, LD_B);
      expect_store(16'h0130, 16'h0000);
      expect_store(16'h0132, 16'h4242);
      expect_store(MARK_ADDR, 16'hbeef);
      expect_store(SYNC_ON, 16'h0000);
      expect_store(SYNC_OFF, 16'h0000);
      expect_store(16'h01f2, 16'h0000);
      expect_store(DONE_ADDR, 16'h600d);
   endtask

   task automatic store_seen(input logic [15:0] a, input logic [15:0] d);
      if ((a[15:8] == 8'h01) && exp_valid[a[7:0]])
      begin
         write_cnt[a[7:0]]++;
         assert (d == exp_val[a[7:0]])
         else
         begin
            value_errors++;
            $display("error: dout at %h expected %h got %h", a, exp_val[a[7:0]], d);
         end
      end
      else
      begin
         other_errors++;
         $display("unexpected store of %h to address %h", d, a);
      end
      if (a == MARK_ADDR)
         marker_seen = 1'b1;
      if (a == DONE_ADDR)
         done_seen = 1'b1;
   endtask

   task automatic check_totals();
      for (int i = 0; i < 256; i++)
      begin
         assert (!exp_valid[i] || (write_cnt[i] == 1))
         else
         begin
            other_errors++;
            $display("result address %h written %0d times", 16'h0100 + i, write_cnt[i]);
         end
      end
      assert ((int_entries == 1) && (returns_checked == 1))
      else
      begin
         other_errors++;
         $display("interrupt entered %0d times and returned %0d times, once each expected",
                  int_entries, returns_checked);
      end
   endtask

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Bus observer, sampled at the edge that ends each cycle
   always @(posedge clk)
   begin
      if (!reset_b)
      begin
         if (reset_seen)
         begin
            assert (rnw)
            else
            begin
               other_errors++;
               $display("write strobe active during reset");
            end
         end
         reset_seen = 1'b1;  // Flops hold their reset values from the first edge on
      end
      else
      begin
         if (first_cycle)
         begin
            assert (address == `OPC5LS_RESET_PC)
            else
            begin
               other_errors++;
               $display("first fetch after reset was not at the reset address");
            end
            first_cycle = 1'b0;
         end
         if (!rnw)
            store_seen(address, dout);
         // The startup jump also reaches address 2, straight from address 1
         if (rnw && (address == `OPC5LS_INT_VECTOR)
             && (prev_addr != (`OPC5LS_INT_VECTOR - 1'b1)))
         begin
            int_entries++;
            ret_addr    = prev_addr;  // Int cycle shows the saved pc
            marker_seen = 1'b0;
            ret_pending = 1'b1;
         end
         if (ret_pending && marker_seen && rnw
             && ((address < `OPC5LS_INT_VECTOR) || (address >= HANDLER_END)))
         begin
            assert (address == ret_addr)
            else
            begin
               value_errors++;
               $display("error: address after rti expected %h got %h", ret_addr, address);
            end
            ret_pending = 1'b0;
            returns_checked++;
         end
      end
      prev_addr = address;
   end

   a_single_write : assert property (@(posedge clk) disable iff (!reset_b) !rnw |=> rnw)
      else
      begin
         other_errors++;
         $display("write strobe held for more than one cycle");
      end

   initial
   begin
      int   delay;
      logic entered;
      reset_b = 1'b0;
      int_b   = 1'b1;
      #1 load_program();
      repeat (2) @(posedge clk);
      reset_b <= 1'b1;
      do
         @(posedge clk);
      while (rnw || (address != SYNC_ON));
      rng   = lcg_next(rng);
      delay = rng[23:16] % 24;
      repeat (delay) @(posedge clk);
      int_b <= 1'b0;
      entered = 1'b0;
      for (int n = 0; (n < 12) && !entered; n++)
      begin
         @(posedge clk);
         entered = rnw && (address == `OPC5LS_INT_VECTOR);
      end
      int_b <= 1'b1;
      assert (entered)
      else
      begin
         other_errors++;
         $display("interrupt request was not taken within 12 cycles");
      end
      do
         @(posedge clk);
      while (rnw || (address != SYNC_OFF));
      int_b <= 1'b0;  // Must be ignored while disabled
      repeat (30) @(posedge clk);
      int_b <= 1'b1;
      wait (done_seen);
      repeat (4) @(posedge clk);
      check_totals();
      $display("errors: value %0d, other %0d", value_errors, other_errors);
      if ((value_errors == 0) && (other_errors == 0))
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns before the program finished", WATCHDOG_NS);
      $display("errors: value %0d, other %0d", value_errors, other_errors);
      $display("Simulation failed");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+.
opc5ls_isa_pkg.sv
opc5ls_ctrl_pkg.sv
opc5ls_decode.sv
opc5ls_execute.sv
opc5ls_result.sv
opc5ls_core.sv
tb_opc5ls_memory.sv
tb_opc5ls_core.sv

// ==== Bender.yml ====
package:
  name: opc5ls

sources:
  - include_dirs:
      - .
    files:
      - opc5ls_isa_pkg.sv
      - opc5ls_ctrl_pkg.sv
      - opc5ls_decode.sv
      - opc5ls_execute.sv
      - opc5ls_result.sv
      - opc5ls_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_opc5ls_memory.sv
      - tb_opc5ls_core.sv
